/* logic/chunky_pkg.sv */
package chunky_pkg;

	// CPU bus widths
	localparam int CPU_ADDR_W = 32;
	localparam int CPU_DATA_W = 32;

	// Palette entry and output pixel, 8 bits each of R, G and B
	typedef logic [23:0] t_colour;

	// Four chunky pixels, byte 0 is the leftmost
	typedef logic [31:0] t_vram_word;

	// CPU byte addresses from here up select the palette
	localparam logic [CPU_ADDR_W-1:0] PALETTE_BASE = 32'h01000000;

	// Clocks spent on each pixel
	// The fetch engine needs 7 at worst
	localparam int PIXEL_DWELL = 8;

endpackage

/* logic/dual_port_ram.sv */
`timescale 1ns/10ps

module dual_port_ram #(
	parameter type t_word = logic [31:0],
	parameter int DEPTH = 256,
	parameter int ADDR_LSH = 0
)(
	input i_clock,

	input i_pa_request,
	input i_pa_rw,
	input [31:0] i_pa_address,
	input t_word i_pa_wdata,
	output t_word o_pa_rdata,
	output logic o_pa_ready,

	input i_pb_request,
	input i_pb_rw,
	input [31:0] i_pb_address,
	input t_word i_pb_wdata,
	output t_word o_pb_rdata,
	output logic o_pb_ready
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	t_word mem [DEPTH];
	logic [AW-1:0] pa_index;
	logic [AW-1:0] pb_index;

	// Byte address down to word index
	assign pa_index = AW'(i_pa_address >> ADDR_LSH);
	assign pb_index = AW'(i_pb_address >> ADDR_LSH);

	// Reads see the old word when a write hits the same entry
	always_ff @(posedge i_clock) begin
		if (i_pa_request) begin
			if (i_pa_rw)
				mem[pa_index] <= i_pa_wdata;
			o_pa_rdata <= mem[pa_index];
		end
		if (i_pb_request) begin
			if (i_pb_rw)
				mem[pb_index] <= i_pb_wdata;
			o_pb_rdata <= mem[pb_index];
		end
	end

	always_ff @(posedge i_clock) begin
		o_pa_ready <= i_pa_request;
		o_pb_ready <= i_pb_request;
	end

endmodule

/* logic/cpu_port_decoder.sv */
`timescale 1ns/10ps

module cpu_port_decoder
	import chunky_pkg::*;
(
	input i_clock,
	input i_rst,

	input i_cpu_request,
	input i_cpu_rw,
	input [CPU_ADDR_W-1:0] i_cpu_address,
	input [CPU_DATA_W-1:0] i_cpu_wdata,
	output [CPU_DATA_W-1:0] o_cpu_rdata,
	output o_cpu_ready,

	output logic o_vram_request,
	output logic o_vram_rw,
	output logic [CPU_ADDR_W-1:0] o_vram_address,
	output logic [CPU_DATA_W-1:0] o_vram_wdata,
	input [CPU_DATA_W-1:0] i_vram_rdata,
	input i_vram_ready,

	output logic o_pal_request,
	output logic [7:0] o_pal_index,
	output t_colour o_pal_colour
);

	logic busy;
	logic target_vram;
	logic pal_ready;
	logic [CPU_ADDR_W-1:0] pal_offset;

	assign pal_offset = i_cpu_address - PALETTE_BASE;

	// One access per request, busy holds off the rest of the held level
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			busy <= 1'b0;
			target_vram <= 1'b0;
			pal_ready <= 1'b0;
			o_vram_request <= 1'b0;
			o_pal_request <= 1'b0;
		end else begin
			o_vram_request <= 1'b0;
			o_pal_request <= 1'b0;
			pal_ready <= 1'b0;
			if (!busy && i_cpu_request) begin
				busy <= 1'b1;
				if (i_cpu_address < PALETTE_BASE) begin
					target_vram <= 1'b1;
					o_vram_request <= 1'b1;
				end else begin
					// Palette is write only, a read just completes
					target_vram <= 1'b0;
					o_pal_request <= i_cpu_rw;
					pal_ready <= 1'b1;
				end
			end else if (o_cpu_ready) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!busy && i_cpu_request) begin
			o_vram_rw <= i_cpu_rw;
			o_vram_address <= i_cpu_address;
			o_vram_wdata <= i_cpu_wdata;
			o_pal_index <= pal_offset[9:2];
			o_pal_colour <= i_cpu_wdata[23:0];
		end
	end

	assign o_cpu_ready = pal_ready | (busy & target_vram & i_vram_ready);
	assign o_cpu_rdata = target_vram ? i_vram_rdata : '0;

endmodule

/* logic/scan_timing.sv */
`timescale 1ns/10ps

module scan_timing
	import chunky_pkg::*;
#(
	parameter int H_ACTIVE = 320,
	parameter int V_ACTIVE = 200
)(
	input i_clock,
	input i_rst,

	output logic [8:0] o_pos_x,
	output logic [8:0] o_pos_y,
	output o_pixel_valid,
	output o_dwell_start
);

	localparam int DW = $clog2(PIXEL_DWELL);
	localparam logic [DW-1:0] DWELL_LAST = DW'(PIXEL_DWELL - 1);

	logic [DW-1:0] dwell;

	// **************************************************************************
	// Dwell and position counters

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			dwell <= '0;
			o_pos_x <= '0;
			o_pos_y <= '0;
		end else if (dwell == DWELL_LAST) begin
			dwell <= '0;
			if (o_pos_x == 9'(H_ACTIVE - 1)) begin
				o_pos_x <= '0;
				if (o_pos_y == 9'(V_ACTIVE - 1))
					o_pos_y <= '0;
				else
					o_pos_y <= o_pos_y + 9'd1;
			end else begin
				o_pos_x <= o_pos_x + 9'd1;
			end
		end else begin
			dwell <= dwell + 1'b1;
		end
	end

	// **************************************************************************
	// Strobes

	// Pixel is sampled on the last clock of its dwell
	assign o_pixel_valid = (dwell == DWELL_LAST);

	// Fetch engine kicks off here
	assign o_dwell_start = (dwell == '0);

endmodule

/* logic/chunky_fetch.sv */
`timescale 1ns/10ps

module chunky_fetch
	import chunky_pkg::*;
#(
	parameter int PPITCH = 320
)(
	input i_clock,
	input i_rst,

	input [8:0] i_pos_x,
	input [8:0] i_pos_y,
	input i_dwell_start,

	output logic o_vram_request,
	output logic [CPU_ADDR_W-1:0] o_vram_address,
	input t_vram_word i_vram_rdata,
	input i_vram_ready,

	output logic [7:0] o_pal_index,
	input t_colour i_pal_colour,

	output t_colour o_pixel_rgb
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_WAIT,
		S_LOOK0,
		S_LOOK1,
		S_LOOK2,
		S_LOOK3
	} t_state;

	t_state state;
	t_vram_word word;
	t_colour quad [4];
	logic [CPU_ADDR_W-1:0] group_address;

	// Leftmost pixel of the group of four on this line
	assign group_address = CPU_ADDR_W'({i_pos_x[8:2], 2'b00})
		+ CPU_ADDR_W'(i_pos_y) * CPU_ADDR_W'(PPITCH);

	// **************************************************************************
	// Fetch FSM

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= S_IDLE;
			o_vram_request <= 1'b0;
		end else begin
			case (state)
			S_IDLE: begin
				if (i_dwell_start && i_pos_x[1:0] == 2'd0) begin
					o_vram_request <= 1'b1;
					state <= S_WAIT;
				end
			end
			S_WAIT: begin
				if (i_vram_ready) begin
					o_vram_request <= 1'b0;
					state <= S_LOOK0;
				end
			end
			S_LOOK0: state <= S_LOOK1;
			S_LOOK1: state <= S_LOOK2;
			S_LOOK2: state <= S_LOOK3;
			default: state <= S_IDLE;
			endcase
		end
	end

	// Byte 0 goes straight to the palette as the word arrives,
	// the rest come from the latched word
	always_comb begin
		case (state)
		S_LOOK0: o_pal_index = word[15:8];
		S_LOOK1: o_pal_index = word[23:16];
		S_LOOK2: o_pal_index = word[31:24];
		default: o_pal_index = i_vram_rdata[7:0];
		endcase
	end

	// **************************************************************************
	// Quad fill and pixel select

	always_ff @(posedge i_clock) begin
		if (state == S_IDLE && i_dwell_start)
			o_vram_address <= group_address;
		if (state == S_WAIT && i_vram_ready)
			word <= i_vram_rdata;
		case (state)
		S_LOOK0: quad[0] <= i_pal_colour;
		S_LOOK1: quad[1] <= i_pal_colour;
		S_LOOK2: quad[2] <= i_pal_colour;
		S_LOOK3: quad[3] <= i_pal_colour;
		default: ;
		endcase
		o_pixel_rgb <= quad[i_pos_x[1:0]];
	end

endmodule

/* logic/chunky_top.sv */
`timescale 1ns/10ps

module chunky_top
	import chunky_pkg::*;
#(
	parameter int PPITCH = 320,
	parameter int H_ACTIVE = 320,
	parameter int V_ACTIVE = 200,
	parameter int VRAM_WORDS = 16000
)(
	input i_clock,
	input i_rst,

	input i_cpu_request,
	input i_cpu_rw,
	input [CPU_ADDR_W-1:0] i_cpu_address,
	input [CPU_DATA_W-1:0] i_cpu_wdata,
	output [CPU_DATA_W-1:0] o_cpu_rdata,
	output o_cpu_ready,

	output o_pixel_valid,
	output t_colour o_pixel_rgb,
	output [8:0] o_pos_x,
	output [8:0] o_pos_y
);

	// CPU side of VRAM
	logic vram_a_request;
	logic vram_a_rw;
	logic [CPU_ADDR_W-1:0] vram_a_address;
	logic [CPU_DATA_W-1:0] vram_a_wdata;
	logic [CPU_DATA_W-1:0] vram_a_rdata;
	logic vram_a_ready;

	logic pal_w_request;
	logic [7:0] pal_w_index;
	t_colour pal_w_colour;

	// Video side
	logic vram_b_request;
	logic [CPU_ADDR_W-1:0] vram_b_address;
	t_vram_word vram_b_rdata;
	logic vram_b_ready;
	logic [7:0] pal_r_index;
	t_colour pal_r_colour;
	logic dwell_start;

	cpu_port_decoder decoder (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_cpu_request(i_cpu_request),
		.i_cpu_rw(i_cpu_rw),
		.i_cpu_address(i_cpu_address),
		.i_cpu_wdata(i_cpu_wdata),
		.o_cpu_rdata(o_cpu_rdata),
		.o_cpu_ready(o_cpu_ready),
		.o_vram_request(vram_a_request),
		.o_vram_rw(vram_a_rw),
		.o_vram_address(vram_a_address),
		.o_vram_wdata(vram_a_wdata),
		.i_vram_rdata(vram_a_rdata),
		.i_vram_ready(vram_a_ready),
		.o_pal_request(pal_w_request),
		.o_pal_index(pal_w_index),
		.o_pal_colour(pal_w_colour)
	);

	dual_port_ram #(
		.t_word(t_vram_word),
		.DEPTH(VRAM_WORDS),
		.ADDR_LSH(2)
	) vram (
		.i_clock(i_clock),
		.i_pa_request(vram_a_request),
		.i_pa_rw(vram_a_rw),
		.i_pa_address(vram_a_address),
		.i_pa_wdata(vram_a_wdata),
		.o_pa_rdata(vram_a_rdata),
		.o_pa_ready(vram_a_ready),
		.i_pb_request(vram_b_request),
		.i_pb_rw(1'b0),
		.i_pb_address(vram_b_address),
		.i_pb_wdata('0),
		.o_pb_rdata(vram_b_rdata),
		.o_pb_ready(vram_b_ready)
	);

	// Port A writes from the CPU, port B reads every clock for the fetch engine
	dual_port_ram #(
		.t_word(t_colour),
		.DEPTH(256),
		.ADDR_LSH(0)
	) palette (
		.i_clock(i_clock),
		.i_pa_request(pal_w_request),
		.i_pa_rw(1'b1),
		.i_pa_address({24'h0, pal_w_index}),
		.i_pa_wdata(pal_w_colour),
		.o_pa_rdata(),
		.o_pa_ready(),
		.i_pb_request(1'b1),
		.i_pb_rw(1'b0),
		.i_pb_address({24'h0, pal_r_index}),
		.i_pb_wdata('0),
		.o_pb_rdata(pal_r_colour),
		.o_pb_ready()
	);

	scan_timing #(
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE)
	) scan (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.o_pos_x(o_pos_x),
		.o_pos_y(o_pos_y),
		.o_pixel_valid(o_pixel_valid),
		.o_dwell_start(dwell_start)
	);

	chunky_fetch #(
		.PPITCH(PPITCH)
	) fetch (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_pos_x(o_pos_x),
		.i_pos_y(o_pos_y),
		.i_dwell_start(dwell_start),
		.o_vram_request(vram_b_request),
		.o_vram_address(vram_b_address),
		.i_vram_rdata(vram_b_rdata),
		.i_vram_ready(vram_b_ready),
		.o_pal_index(pal_r_index),
		.i_pal_colour(pal_r_colour),
		.o_pixel_rgb(o_pixel_rgb)
	);

endmodule

/* test/chunky_assertions.sv */
`timescale 1ns/10ps

module chunky_assertions
	import chunky_pkg::*;
(
	input i_clock,
	input i_rst,
	input i_cpu_request,
	input [CPU_ADDR_W-1:0] i_cpu_address,
	input i_cpu_ready,
	input i_pixel_valid,
	input i_dwell_start,
	input i_fetch_request
);

	int unsigned since_valid;
	int ready_fails = 0;
	int vram_fails = 0;
	int pal_fails = 0;
	int pace_fails = 0;
	int overlap_fails = 0;
	int failures;

	assign failures = ready_fails + vram_fails + pal_fails + pace_fails + overlap_fails;

	// Clocks since the last pixel strobe
	always_ff @(posedge i_clock) begin
		if (i_rst)
			since_valid <= 0;
		else if (i_pixel_valid)
			since_valid <= 0;
		else
			since_valid <= since_valid + 1;
	end

	// **************************************************************************
	// CPU port

	ready_needs_request: assert property (@(posedge i_clock) disable iff (i_rst)
		i_cpu_ready |-> i_cpu_request)
	else begin
		$error("CPU ready without a pending request");
		ready_fails++;
	end

	vram_latency: assert property (@(posedge i_clock) disable iff (i_rst)
		$rose(i_cpu_request) && i_cpu_address < PALETTE_BASE
			|-> !i_cpu_ready ##1 !i_cpu_ready ##1 i_cpu_ready)
	else begin
		$error("VRAM access ready not 2 cycles after request");
		vram_fails++;
	end

	palette_latency: assert property (@(posedge i_clock) disable iff (i_rst)
		$rose(i_cpu_request) && i_cpu_address >= PALETTE_BASE
			|-> !i_cpu_ready ##1 i_cpu_ready)
	else begin
		$error("Palette access ready not 1 cycle after request");
		pal_fails++;
	end

	// **************************************************************************
	// Video side

	// Strobe exactly on the last clock of every dwell, so 8 apart
	pixel_pace: assert property (@(posedge i_clock) disable iff (i_rst)
		i_pixel_valid == (since_valid == PIXEL_DWELL - 1))
	else begin
		$error("Pixel valid strobes not %0d cycles apart", PIXEL_DWELL);
		pace_fails++;
	end

	fetch_clear_of_dwell_start: assert property (@(posedge i_clock) disable iff (i_rst)
		!(i_fetch_request && i_dwell_start))
	else begin
		$error("Fetch VRAM request overlaps a dwell start");
		overlap_fails++;
	end

endmodule

bind chunky_top chunky_assertions chk (
	.i_clock(i_clock),
	.i_rst(i_rst),
	.i_cpu_request(i_cpu_request),
	.i_cpu_address(i_cpu_address),
	.i_cpu_ready(o_cpu_ready),
	.i_pixel_valid(o_pixel_valid),
	.i_dwell_start(dwell_start),
	.i_fetch_request(vram_b_request)
);

/* test/chunky_tb.sv */
`timescale 1ns/10ps

module chunky_tb
	import chunky_pkg::*;
();

	localparam int PPITCH = 16;
	localparam int H_ACTIVE = 16;
	localparam int V_ACTIVE = 8;
	localparam int VRAM_WORDS = 32;
	localparam int CPU_TIMEOUT = 16;

	logic clock;
	logic rst;
	logic cpu_request;
	logic cpu_rw;
	logic [31:0] cpu_address;
	logic [31:0] cpu_wdata;
	logic [31:0] cpu_rdata;
	logic cpu_ready;
	logic pixel_valid;
	t_colour pixel_rgb;
	logic [8:0] pos_x;
	logic [8:0] pos_y;

	// Reference copies of everything the CPU wrote
	t_vram_word shadow_vram [VRAM_WORDS];
	t_colour shadow_pal [256];

	int checks = 0;
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	chunky_top #(
		.PPITCH(PPITCH),
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE),
		.VRAM_WORDS(VRAM_WORDS)
	) uut (
		.i_clock(clock),
		.i_rst(rst),
		.i_cpu_request(cpu_request),
		.i_cpu_rw(cpu_rw),
		.i_cpu_address(cpu_address),
		.i_cpu_wdata(cpu_wdata),
		.o_cpu_rdata(cpu_rdata),
		.o_cpu_ready(cpu_ready),
		.o_pixel_valid(pixel_valid),
		.o_pixel_rgb(pixel_rgb),
		.o_pos_x(pos_x),
		.o_pos_y(pos_y)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// **************************************************************************
	// Helpers

	task automatic check_value(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			test_errors++;
			$display("[ERROR] %s: expected %h, actual %h", test, expected, actual);
		end
	endtask

	task automatic report_timeout(input string test, input string what);
		errors++;
		test_errors++;
		$display("%s: gave up waiting for %s", test, what);
	endtask

	task automatic finish_test(input string test);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("%s %s: %0d errors", (test_errors == 0) ? "[PASS]" : "[FAIL]", test,
			test_errors);
		test_errors = 0;
	endtask

	// One CPU request, held until ready, latency counted in cycles
	task automatic cpu_access(input string test, input logic rw, input logic [31:0] address,
		input logic [31:0] wdata, output logic [31:0] rdata, output int latency);
		int n;
		latency = -1;
		rdata = '0;
		@(posedge clock);
		cpu_request <= 1'b1;
		cpu_rw <= rw;
		cpu_address <= address;
		cpu_wdata <= wdata;
		for (n = 0; n < CPU_TIMEOUT && latency < 0; n++) begin
			@(posedge clock);
			if (cpu_ready) begin
				latency = n;
				rdata = cpu_rdata;
			end
		end
		cpu_request <= 1'b0;
		if (latency < 0)
			report_timeout(test, "CPU ready");
	endtask

	task automatic wait_pixel(input string test, output logic ok, output logic [8:0] x,
		output logic [8:0] y, output t_colour rgb);
		int n;
		ok = 1'b0;
		for (n = 0; n <= PIXEL_DWELL && !ok; n++) begin
			@(posedge clock);
			ok = pixel_valid;
			x = pos_x;
			y = pos_y;
			rgb = pixel_rgb;
		end
		if (!ok)
			report_timeout(test, "pixel valid");
	endtask

	// Sync to the end of the current frame, then check every pixel of the next one
	task automatic check_frame(input string test);
		logic ok;
		logic [8:0] x;
		logic [8:0] y;
		t_colour rgb;
		t_vram_word word;
		int offset;
		int n;
		ok = 1'b1;
		x = '0;
		y = '0;
		for (n = 0; n <= H_ACTIVE * V_ACTIVE && ok
			&& !(x == H_ACTIVE - 1 && y == V_ACTIVE - 1); n++)
			wait_pixel(test, ok, x, y, rgb);
		if (ok && !(x == H_ACTIVE - 1 && y == V_ACTIVE - 1))
			report_timeout(test, "end of frame");
		for (n = 0; n < H_ACTIVE * V_ACTIVE && ok; n++) begin
			wait_pixel(test, ok, x, y, rgb);
			if (ok) begin
				check_value(test, n % H_ACTIVE, x);
				check_value(test, n / H_ACTIVE, y);
				offset = (n % H_ACTIVE) + (n / H_ACTIVE) * PPITCH;
				word = shadow_vram[offset / 4];
				check_value(test, shadow_pal[word[8 * (offset % 4) +: 8]], rgb);
			end
		end
	endtask

	// **************************************************************************
	// Test sequence

	initial begin
		logic [31:0] rdata;
		logic [31:0] wdata;
		logic [7:0] entry;
		logic ok;
		logic [8:0] x;
		logic [8:0] y;
		t_colour rgb;
		int latency;
		int n;

		void'($urandom(32'hd2f6));
		rst = 1'b1;
		cpu_request = 1'b0;
		cpu_rw = 1'b0;
		cpu_address = '0;
		cpu_wdata = '0;

		repeat (4) @(posedge clock);
		rst <= 1'b0;
		ok = 1'b0;
		latency = -1;
		for (n = 1; n <= 2 * PIXEL_DWELL && !ok; n++) begin
			@(posedge clock);
			check_value("reset", 0, cpu_ready);
			if (pixel_valid) begin
				ok = 1'b1;
				latency = n;
				x = pos_x;
				y = pos_y;
			end
		end
		if (!ok)
			report_timeout("reset", "first pixel");
		check_value("reset", PIXEL_DWELL, latency);
		check_value("reset", 0, x);
		check_value("reset", 0, y);
		finish_test("reset");

		for (n = 0; n < 256; n++) begin
			wdata = $urandom;
			cpu_access("palette_write", 1'b1, PALETTE_BASE + 4 * n, wdata, rdata, latency);
			shadow_pal[n] = wdata[23:0];
			check_value("palette_write", 1, latency);
		end
		finish_test("palette_write");

		for (n = 0; n < VRAM_WORDS; n++) begin
			wdata = $urandom;
			cpu_access("vram_readback", 1'b1, 4 * n, wdata, rdata, latency);
			shadow_vram[n] = wdata;
			check_value("vram_readback", 2, latency);
		end
		for (n = 0; n < VRAM_WORDS; n++) begin
			cpu_access("vram_readback", 1'b0, 4 * n, '0, rdata, latency);
			check_value("vram_readback", 2, latency);
			check_value("vram_readback", shadow_vram[n], rdata);
		end
		finish_test("vram_readback");

		check_frame("pixel_stream");
		finish_test("pixel_stream");

		// Rewrite halfway down the frame
		ok = 1'b1;
		y = '0;
		for (n = 0; n < H_ACTIVE * V_ACTIVE && ok && y != V_ACTIVE / 2; n++)
			wait_pixel("live_update", ok, x, y, rgb);
		wdata = $urandom;
		cpu_access("live_update", 1'b1, 32'd20, wdata, rdata, latency);
		shadow_vram[5] = wdata;
		entry = shadow_vram[0][7:0];
		wdata = $urandom;
		cpu_access("live_update", 1'b1, PALETTE_BASE + 4 * entry, wdata, rdata, latency);
		shadow_pal[entry] = wdata[23:0];
		check_frame("live_update");
		finish_test("live_update");

		wdata = $urandom;
		entry = wdata[7:0];
		cpu_access("palette_read", 1'b0, PALETTE_BASE + 4 * entry, '0, rdata, latency);
		check_value("palette_read", 1, latency);
		check_frame("palette_read");
		finish_test("palette_read");

		repeat (2) @(posedge clock);
		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, checks, errors, uut.chk.failures);
		if (errors == 0 && tests_failed == 0 && uut.chk.failures == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
logic/chunky_pkg.sv
logic/dual_port_ram.sv
logic/cpu_port_decoder.sv
logic/scan_timing.sv
logic/chunky_fetch.sv
logic/chunky_top.sv
test/chunky_assertions.sv
test/chunky_tb.sv
